// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] data;
    } store_t;

    logic                 clk;
    logic                 reset;
    logic                 irq;
    logic [31:0]          instruction;
    logic [63:0]          pc;
    rv_bus_pkg::bus_req_t bus_req;
    logic                 bus_req_valid;
    logic                 bus_req_ready;
    rv_bus_pkg::bus_rsp_t bus_rsp;
    logic                 bus_rsp_valid;

    logic [31:0] rom [0:255];          // Word per pc[9:2]
    logic [63:0] mem [logic [63:0]];   // Sparse data memory
    store_t      exp_q [$];            // Scoreboard in program order
    int          ptr;
    int          errors;
    int          checked;
    int          wait_cnt;
    int          cycles;
    logic        busy;
    logic        done;
    logic        outstanding;          // Accepted but not yet answered
    logic        last_valid;
    logic        last_ready;
    logic        last_hold;
    logic [63:0] last_pc;
    logic        seen_irq_vec;
    logic        seen_ill_vec;
    rv_bus_pkg::bus_req_t last_req;

    rv_core dut0 (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .pc            (pc),
        .bus_req       (bus_req),
        .bus_req_valid (bus_req_valid),
        .bus_req_ready (bus_req_ready),
        .bus_rsp       (bus_rsp),
        .bus_rsp_valid (bus_rsp_valid),
        .irq           (irq)
    );

    always #5 clk = ~clk;

    assign instruction = rom[pc[9:2]];  // Combinational fetch

    // Hand assembler
    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] sd_word(int rs2, int imm, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] add_word(int rd, int rs1, int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_word(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] csrrw_word(int rd, logic [11:0] csr, int rs1);
        return {csr, rs1[4:0], 3'b001, rd[4:0], 7'b1110011};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[ptr] = w;
        ptr++;
    endtask

    task automatic expect_store(input logic [63:0] a, input logic [63:0] d);
        exp_q.push_back({a, d});
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++)
            rom[i] = 32'h0;                      // NOP filler
        ptr = 44 / 4;                            // Main code at reset pc
        emit(lui_word(1, 20'h12345));            // x1 = 0x12345000
        emit(i_type(12'h678, 1, 0, 2, 7'h13));   // x2 = x1 + 0x678
        emit(add_word(3, 1, 2));
        emit(i_type(5, 1, 0, 0, 7'h13));         // Write to x0 is dropped
        emit(sd_word(1, 12'h400, 0));
        emit(sd_word(2, 12'h408, 0));
        emit(sd_word(3, 12'h410, 0));
        emit(sd_word(0, 12'h418, 0));
        emit(i_type(-3, 0, 0, 4, 7'h13));        // Negative immediate
        emit(sd_word(4, 12'h420, 0));
        emit(i_type(12'h408, 0, 3, 5, 7'h03));   // LD x5 back
        emit(sd_word(5, 12'h428, 0));
        emit(i_type(12'h200, 0, 0, 8, 7'h13));
        emit(csrrw_word(0, `RV_CSR_MTVEC, 8));
        emit(i_type(8, 0, 0, 9, 7'h13));         // MIE bit
        emit(lui_word(10, 1));
        emit(i_type(-2048, 10, 0, 10, 7'h13));   // x10 = 0x800 for MEIE
        emit(csrrw_word(0, `RV_CSR_MIE, 10));
        emit(sd_word(10, 12'h430, 0));           // Still runs with irq high
        emit(csrrw_word(0, `RV_CSR_MSTATUS, 9));
        emit(i_type(77, 0, 0, 11, 7'h13));       // pc 124 is replaced by the interrupt
        emit(sd_word(11, 12'h438, 0));
        emit(i_type(12'h280, 0, 0, 8, 7'h13));
        emit(csrrw_word(0, `RV_CSR_MTVEC, 8));
        emit(32'hFFFF_FFFF);                     // Illegal word at pc 140
        emit(i_type(99, 0, 0, 12, 7'h13));
        emit(sd_word(12, 12'h440, 0));
        emit(sd_word(0, 12'h500, 0));            // End marker
        ptr = 12'h200 / 4;                       // Interrupt handler
        emit(csrrw_word(5, `RV_CSR_MCAUSE, 0));
        emit(csrrw_word(6, `RV_CSR_MEPC, 0));
        emit(sd_word(5, 12'h600, 0));
        emit(sd_word(6, 12'h608, 0));
        emit(csrrw_word(0, `RV_CSR_MEPC, 6));    // Restore return address
        emit(sd_word(0, 12'h700, 0));            // Device store drops irq
        emit(32'h3020_0073);
        ptr = 12'h280 / 4;                       // Illegal handler skips the bad word
        emit(csrrw_word(5, `RV_CSR_MCAUSE, 0));
        emit(csrrw_word(6, `RV_CSR_MEPC, 0));
        emit(sd_word(5, 12'h610, 0));
        emit(sd_word(6, 12'h618, 0));
        emit(i_type(4, 6, 0, 6, 7'h13));
        emit(csrrw_word(0, `RV_CSR_MEPC, 6));
        emit(32'h3020_0073);
    endtask

    // Architectural effects of the program worked out by hand
    task automatic build_scoreboard();
        expect_store(64'h400, 64'h1234_5000);
        expect_store(64'h408, 64'h1234_5678);
        expect_store(64'h410, 64'h2468_A678);
        expect_store(64'h418, 64'h0);
        expect_store(64'h420, 64'hFFFF_FFFF_FFFF_FFFD);
        expect_store(64'h428, 64'h1234_5678);     // Loaded value
        expect_store(64'h430, 64'h800);
        expect_store(64'h600, 64'h8000_0000_0000_000B);
        expect_store(64'h608, 64'd124);
        expect_store(64'h700, 64'h0);
        expect_store(64'h438, 64'd77);
        expect_store(64'h610, 64'd2);
        expect_store(64'h618, 64'd140);
        expect_store(64'h440, 64'd99);
        expect_store(64'h500, 64'h0);
    endtask

    // Data memory with random ready and 1 to 3 cycle answers
    always @(posedge clk) begin
        store_t e;
        if (reset) begin
            bus_rsp_valid <= 1'b0;
            if (busy) begin
                bus_req_ready <= 1'b0;
                if (wait_cnt == 0) begin
                    bus_rsp_valid <= 1'b1;
                    busy          <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (bus_req_valid && bus_req_ready) begin
                busy          <= 1'b1;
                wait_cnt      <= int'($urandom_range(2, 0));
                bus_req_ready <= 1'b0;
                if (bus_req.write) begin
                    mem[bus_req.addr] = bus_req.wdata;
                    checked++;
                    if (bus_req.addr == 64'h700)
                        irq <= 1'b0;
                    if (bus_req.addr == 64'h500)
                        done <= 1'b1;
                    if (exp_q.size() == 0) begin
                        note_failure("store beyond the end of the program");
                    end else begin
                        e = exp_q.pop_front();
                        assert (bus_req.addr == e.addr && bus_req.wdata == e.data)
                        else report_mismatch($sformatf("store %h=%h, expected %h=%h",
                                             bus_req.addr, bus_req.wdata, e.addr, e.data));
                    end
                end else begin
                    bus_rsp.rdata <= mem.exists(bus_req.addr) ? mem[bus_req.addr] : 64'h0;
                end
            end else begin
                bus_req_ready <= 1'($urandom % 2);
            end
        end
    end

    // Bus protocol and pc trace
    always @(posedge clk) begin
        if (reset) begin
            if (last_valid && !last_ready) begin
                assert (bus_req_valid) else note_failure("valid dropped before ready");
                assert (bus_req == last_req)
                else note_failure("request changed while waiting");
            end
            assert (!(bus_req_valid && outstanding))
            else note_failure("second request before the response");
            if (last_hold) begin
                assert (pc == last_pc) else note_failure("pc moved during a bus transaction");
            end else if (pc != last_pc) begin
                assert (pc == last_pc + 64'd4 || pc == 64'h200 || pc == 64'h280 ||
                        pc == 64'd124 || pc == 64'd144)
                else report_mismatch($sformatf("pc step %0d -> %0d", last_pc, pc));
            end
            if (pc == 64'h200)
                seen_irq_vec <= 1'b1;
            if (pc == 64'h280)
                seen_ill_vec <= 1'b1;
            if (bus_rsp_valid)
                outstanding <= 1'b0;
            if (bus_req_valid && bus_req_ready)
                outstanding <= 1'b1;
            last_valid <= bus_req_valid;
            last_ready <= bus_req_ready;
            last_req   <= bus_req;
            last_pc    <= pc;
            last_hold  <= bus_req_valid || (outstanding && !bus_rsp_valid);
        end
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b0;
        irq           = 1'b1;  // High from the start and gated by MIE and MEIE
        bus_req_ready = 1'b0;
        bus_rsp_valid = 1'b0;
        bus_rsp       = '0;
        busy          = 1'b0;
        done          = 1'b0;
        outstanding   = 1'b0;
        last_valid    = 1'b0;
        last_ready    = 1'b0;
        last_hold     = 1'b0;
        last_pc       = `RV_RESET_PC;
        last_req      = '0;
        seen_irq_vec  = 1'b0;
        seen_ill_vec  = 1'b0;
        errors        = 0;
        checked       = 0;
        wait_cnt      = 0;
        void'($urandom(53));
        load_program();
        build_scoreboard();
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        cycles = 0;
        while (!done && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
            note_failure("timeout waiting for the end-of-program store");
        repeat (5) @(posedge clk);
        assert (exp_q.size() == 0) else note_failure("expected stores never appeared");
        assert (seen_irq_vec) else note_failure("interrupt never reached mtvec");
        assert (seen_ill_vec) else note_failure("illegal instruction never reached mtvec");
        $display("Errors: %0d, stores checked: %0d", errors, checked);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
rm -f sim.log
verilator --binary --timing -f tb.f --top-module tb_rv_core -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation failed"
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/rv_bus_pkg.sv ====
package rv_bus_pkg;

`include "rv_cfg.svh"

    // Data-bus request, held stable while valid and not ready
    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;  // Ignored on reads
        logic                write;  // 1 for SD, 0 for LD
    } bus_req_t;

    // Data-bus response, one pulse per accepted request
    typedef struct packed {
        logic [`RV_XLEN-1:0] rdata;  // Only meaningful for reads
    } bus_rsp_t;

endpackage

// ==== src/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Core data width
`define RV_XLEN 64

// First fetch address after reset
`define RV_RESET_PC 64'd44

// Machine CSR addresses, 12-bit
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MIE     12'h304
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342

// MRET encoding, matched as a whole word
`define RV_MRET_WORD 32'h3020_0073

`endif

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           instruction,
    output logic [`RV_XLEN-1:0]   pc,
    output rv_bus_pkg::bus_req_t  bus_req,
    output logic                  bus_req_valid,
    input  logic                  bus_req_ready,
    input  rv_bus_pkg::bus_rsp_t  bus_rsp,
    input  logic                  bus_rsp_valid,
    input  logic                  irq
);

    rv_isa_pkg::decoded_t dec;
    logic [31:0]          instr_word;

    // Register file ports
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic                rf_we;
    logic [4:0]          rf_rd;
    logic [`RV_XLEN-1:0] rf_wdata;

    // Trap unit ports
    logic [11:0]         csr_addr;
    logic [`RV_XLEN-1:0] csr_wdata;
    logic                csr_we;
    logic                illegal;
    logic                mret;
    logic                retire_ok;
    logic [`RV_XLEN-1:0] cur_pc;
    logic [`RV_XLEN-1:0] csr_rdata;
    logic                take_trap;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    rv_decode u_decode (
        .instr (instr_word),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .rd     (rf_rd),
        .wdata  (rf_wdata)
    );

    rv_trap_csr u_trap_csr (
        .clk         (clk),
        .reset       (reset),
        .irq         (irq),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_we      (csr_we),
        .illegal     (illegal),
        .mret        (mret),
        .retire_ok   (retire_ok),
        .cur_pc      (cur_pc),
        .csr_rdata   (csr_rdata),
        .take_trap   (take_trap),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    rv_exec u_exec (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .pc            (pc),
        .dec           (dec),
        .instr_word    (instr_word),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .rf_we         (rf_we),
        .rf_rd         (rf_rd),
        .rf_wdata      (rf_wdata),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_we        (csr_we),
        .illegal       (illegal),
        .mret          (mret),
        .retire_ok     (retire_ok),
        .cur_pc        (cur_pc),
        .csr_rdata     (csr_rdata),
        .take_trap     (take_trap),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .bus_req       (bus_req),
        .bus_req_valid (bus_req_valid),
        .bus_req_ready (bus_req_ready),
        .bus_rsp       (bus_rsp),
        .bus_rsp_valid (bus_rsp_valid)
    );

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
    input  logic [31:0]           instr,
    output rv_isa_pkg::decoded_t  dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediates, all sign-extended from bit 31
    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        // Register and CSR fields sit at fixed positions
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.csr = instr[31:20];
        dec.imm = imm_i;                   // I-type unless overridden
        dec.op  = rv_isa_pkg::OP_ILLEGAL;  // Until something matches

        case (opcode)
            7'b0110111: begin  // LUI
                dec.op  = rv_isa_pkg::OP_LUI;
                dec.imm = imm_u;
            end
            7'b0010011: begin  // OP-IMM
                if (funct3 == 3'b000)
                    dec.op = rv_isa_pkg::OP_ADDI;
            end
            7'b0110011: begin  // OP, only ADD
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    dec.op = rv_isa_pkg::OP_ADD;
            end
            7'b0000011: begin  // LOAD
                if (funct3 == 3'b011)
                    dec.op = rv_isa_pkg::OP_LD;
            end
            7'b0100011: begin  // STORE
                dec.imm = imm_s;
                if (funct3 == 3'b011)
                    dec.op = rv_isa_pkg::OP_SD;
            end
            7'b1110011: begin  // SYSTEM
                if (funct3 == 3'b001)
                    dec.op = rv_isa_pkg::OP_CSRRW;
                else if (instr == `RV_MRET_WORD)
                    dec.op = rv_isa_pkg::OP_MRET;
            end
            default: ;  // Stays illegal
        endcase

        // Zero word is the reset filler, not an error
        if (instr == 32'h0)
            dec.op = rv_isa_pkg::OP_NOP;
    end

endmodule

// ==== src/rv_exec.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           instruction,  // Word at pc, same cycle
    output logic [`RV_XLEN-1:0]   pc,
    input  rv_isa_pkg::decoded_t  dec,
    output logic [31:0]           instr_word,   // Fetch register to decoder
    input  logic [`RV_XLEN-1:0]   rdata1,
    input  logic [`RV_XLEN-1:0]   rdata2,
    output logic                  rf_we,
    output logic [4:0]            rf_rd,
    output logic [`RV_XLEN-1:0]   rf_wdata,
    output logic [11:0]           csr_addr,
    output logic [`RV_XLEN-1:0]   csr_wdata,
    output logic                  csr_we,
    output logic                  illegal,
    output logic                  mret,
    output logic                  retire_ok,
    output logic [`RV_XLEN-1:0]   cur_pc,
    input  logic [`RV_XLEN-1:0]   csr_rdata,
    input  logic                  take_trap,
    input  logic                  redirect,
    input  logic [`RV_XLEN-1:0]   redirect_pc,
    output rv_bus_pkg::bus_req_t  bus_req,
    output logic                  bus_req_valid,
    input  logic                  bus_req_ready,
    input  rv_bus_pkg::bus_rsp_t  bus_rsp,
    input  logic                  bus_rsp_valid
);

    rv_isa_pkg::exec_state_e state;
    rv_isa_pkg::exec_state_e state_next;

    logic [31:0]         fetch_ir;  // Instruction under execution
    logic [`RV_XLEN-1:0] fetch_pc;  // Its address
    logic                bubble;    // Fetch register holds a wrong-path word

    logic issue;      // Fetch register executes this cycle
    logic redir_now;
    logic bus_start;
    logic bus_done;
    logic fetch_en;   // Capture new word, advance pc
    logic alu_op;

    assign issue     = (state == rv_isa_pkg::EX_RUN) && !bubble;
    assign redir_now = issue && redirect;
    assign bus_start = issue && !take_trap &&
                       (dec.op == rv_isa_pkg::OP_LD || dec.op == rv_isa_pkg::OP_SD);
    assign bus_done  = (state == rv_isa_pkg::EX_BUS_WAIT) && bus_rsp_valid;
    // Held through the bus transaction, released on the response edge
    assign fetch_en  = ((state == rv_isa_pkg::EX_RUN) && !bus_start) || bus_done;

    assign instr_word = fetch_ir;

    // Trap side, raw flags plus the retire qualifier
    assign retire_ok = issue;
    assign cur_pc    = fetch_pc;
    assign illegal   = (dec.op == rv_isa_pkg::OP_ILLEGAL);
    assign mret      = (dec.op == rv_isa_pkg::OP_MRET);
    assign csr_addr  = dec.csr;
    assign csr_wdata = rdata1;
    assign csr_we    = issue && !take_trap && (dec.op == rv_isa_pkg::OP_CSRRW);

    // Single-cycle writers
    assign alu_op = (dec.op == rv_isa_pkg::OP_LUI)  || (dec.op == rv_isa_pkg::OP_ADDI) ||
                    (dec.op == rv_isa_pkg::OP_ADD)  || (dec.op == rv_isa_pkg::OP_CSRRW);

    assign rf_rd = dec.rd;
    assign rf_we = (issue && !take_trap && alu_op) ||
                   (bus_done && dec.op == rv_isa_pkg::OP_LD);  // Load lands on response

    always_comb begin
        case (dec.op)
            rv_isa_pkg::OP_LUI:   rf_wdata = dec.imm;
            rv_isa_pkg::OP_ADDI:  rf_wdata = rdata1 + dec.imm;
            rv_isa_pkg::OP_ADD:   rf_wdata = rdata1 + rdata2;
            rv_isa_pkg::OP_CSRRW: rf_wdata = csr_rdata;      // Old CSR value
            default:              rf_wdata = bus_rsp.rdata;  // LD
        endcase
    end

    // Request is stable, since fetch reg and registers hold during bus states
    assign bus_req.addr  = rdata1 + dec.imm;
    assign bus_req.wdata = rdata2;
    assign bus_req.write = (dec.op == rv_isa_pkg::OP_SD);
    assign bus_req_valid = (state == rv_isa_pkg::EX_BUS_REQ);

    always_comb begin
        state_next = state;
        case (state)
            rv_isa_pkg::EX_RUN:
                if (bus_start) state_next = rv_isa_pkg::EX_BUS_REQ;
            rv_isa_pkg::EX_BUS_REQ:
                if (bus_req_ready) state_next = rv_isa_pkg::EX_BUS_WAIT;  // Handshake
            rv_isa_pkg::EX_BUS_WAIT:
                if (bus_rsp_valid) state_next = rv_isa_pkg::EX_RUN;
            default:
                state_next = rv_isa_pkg::EX_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= rv_isa_pkg::EX_RUN;
            pc       <= `RV_RESET_PC;
            fetch_ir <= 32'h0;  // Decodes as NOP
            fetch_pc <= `RV_RESET_PC;
            bubble   <= 1'b0;
        end else begin
            state  <= state_next;
            bubble <= redir_now;  // One dead cycle per redirect
            if (redir_now)
                pc <= redirect_pc;
            else if (fetch_en)
                pc <= pc + 4;
            if (fetch_en) begin
                fetch_ir <= instruction;
                fetch_pc <= pc;
            end
        end
    end

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

`include "rv_cfg.svh"

    // Operations the core knows
    // Nine values, so four bits
    typedef enum logic [3:0] {
        OP_NOP,     // All-zero word
        OP_LUI,
        OP_ADDI,
        OP_ADD,
        OP_LD,      // Doubleword load over the data bus
        OP_SD,      // Doubleword store over the data bus
        OP_CSRRW,
        OP_MRET,
        OP_ILLEGAL  // Anything not matched above
    } op_e;

    // Execute stage state
    typedef enum logic [1:0] {
        EX_RUN,      // One instruction per cycle
        EX_BUS_REQ,  // Request valid, waiting for ready
        EX_BUS_WAIT  // Request accepted, waiting for response
    } exec_state_e;

    // Decoded instruction, built from the fetch register
    typedef struct packed {
        op_e                 op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;  // Sign-extended, U/I/S by op
        logic [11:0]         csr;  // CSR address field
    } decoded_t;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic                we,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] wdata
);

    // x1..x31 only, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin  // Drop writes to x0
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, same-edge writes seen next cycle
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_trap_csr.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_trap_csr (
    input  logic                clk,
    input  logic                reset,
    input  logic                irq,        // Level-sensitive external interrupt
    input  logic [11:0]         csr_addr,
    input  logic [`RV_XLEN-1:0] csr_wdata,
    input  logic                csr_we,     // Already qualified by execute
    input  logic                illegal,
    input  logic                mret,
    input  logic                retire_ok,  // Instruction in fetch reg executes now
    input  logic [`RV_XLEN-1:0] cur_pc,
    output logic [`RV_XLEN-1:0] csr_rdata,
    output logic                take_trap,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc
);

    logic                mstatus_mie;   // mstatus[3]
    logic                mstatus_mpie;  // mstatus[7]
    logic                mie_meie;      // mie[11]
    logic [`RV_XLEN-1:0] mtvec;
    logic [`RV_XLEN-1:0] mepc;
    logic [`RV_XLEN-1:0] mcause;

    logic irq_take;

    // Interrupt wins over whatever sits in the fetch register
    assign irq_take  = irq && mstatus_mie && mie_meie;
    assign take_trap = irq_take || illegal;
    assign redirect  = take_trap || mret;
    assign redirect_pc = take_trap ? mtvec : mepc;

    // Old value for CSRRW
    always_comb begin
        case (csr_addr)
            `RV_CSR_MSTATUS: begin
                csr_rdata = '0;
                csr_rdata[3] = mstatus_mie;
                csr_rdata[7] = mstatus_mpie;
            end
            `RV_CSR_MIE: begin
                csr_rdata = '0;
                csr_rdata[11] = mie_meie;
            end
            `RV_CSR_MTVEC:  csr_rdata = mtvec;
            `RV_CSR_MEPC:   csr_rdata = mepc;
            `RV_CSR_MCAUSE: csr_rdata = mcause;
            default:        csr_rdata = '0;  // Unknown CSRs read zero
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (retire_ok && take_trap) begin
            mepc         <= cur_pc;        // Replaced instruction restarts here
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            if (irq_take)
                mcause <= {1'b1, {(`RV_XLEN-5){1'b0}}, 4'd11};  // Machine external
            else
                mcause <= {{(`RV_XLEN-2){1'b0}}, 2'd2};         // Illegal instruction
        end else if (retire_ok && mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                `RV_CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                `RV_CSR_MIE:    mie_meie <= csr_wdata[11];
                `RV_CSR_MTVEC:  mtvec    <= {csr_wdata[`RV_XLEN-1:2], 2'b00};  // Direct mode
                `RV_CSR_MEPC:   mepc     <= {csr_wdata[`RV_XLEN-1:2], 2'b00};
                `RV_CSR_MCAUSE: mcause   <= csr_wdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== tb.f ====
+incdir+src
src/rv_isa_pkg.sv
src/rv_bus_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_trap_csr.sv
src/rv_exec.sv
src/rv_core.sv
bench/tb_rv_core.sv
